// File: Makefile
# Verilator build and run for the gaussian blur testbench

VERILATOR ?= verilator
TOP       ?= gaussian_blur_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+logic
logic/blur_pkg.sv
logic/blur_csr.sv
logic/window_decode.sv
logic/blur_execute.sv
logic/blur_result.sv
logic/gaussian_blur_top.sv
verification/gaussian_blur_assertions.sv
verification/gaussian_blur_tb.sv

// File: logic/blur_csr.sv
// blur register block, AXI4-Lite slave with enable/bypass control and a frame counter
`timescale 1ns/1ns
`include "blur_macros.svh"

module blur_csr import blur_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  axil_req_t  axil_req,
    input  logic       frame_start,
    output axil_rsp_t  axil_rsp,
    output blur_ctrl_t ctrl
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        wr_fire;
    logic        rd_fire;
    logic        wr_mapped;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [1:0]  rresp_q;
    logic [31:0] rdata_q;
    logic [31:0] frame_cnt;
    blur_ctrl_t  ctrl_q;

    // address and data are taken together, only while no write response waits
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_fire = axil_req.arvalid && !rvalid_q;

    assign wr_mapped = (axil_req.awaddr == `BLUR_REG_CTRL) ||
                       (axil_req.awaddr == `BLUR_REG_STATUS);

    // write response state and control bits
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            ctrl_q   <= '0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                // only byte lane 0 carries the control bits
                if (axil_req.awaddr == `BLUR_REG_CTRL && axil_req.wstrb[0]) begin
                    ctrl_q.enable <= axil_req.wdata[0];
                    ctrl_q.bypass <= axil_req.wdata[1];
                end
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // read response state
    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (axil_req.araddr)
                `BLUR_REG_CTRL: begin
                    rdata_q <= {30'd0, ctrl_q.bypass, ctrl_q.enable};
                    rresp_q <= RESP_OKAY;
                end
                `BLUR_REG_STATUS: begin
                    rdata_q <= frame_cnt;
                    rresp_q <= RESP_OKAY;
                end
                default: begin
                    rdata_q <= '0;
                    rresp_q <= RESP_SLVERR;
                end
            endcase
        end
    end

    // one count per vsync rising edge, wraps at 32 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_cnt <= '0;
        end else if (frame_start) begin
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = rd_fire;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

    assign ctrl = ctrl_q;

endmodule

// File: logic/blur_execute.sv
// blur execute stage, 1-2-1 weighted sum over the 3x3 window
`timescale 1ns/1ns
`include "blur_macros.svh"

module blur_execute import blur_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  window_t    window,
    output sum_stage_t stage
);

    logic [`BLUR_SUM_W-1:0] corner_sum;
    logic [`BLUR_SUM_W-1:0] edge_sum;
    logic [`BLUR_SUM_W-1:0] weighted;
    logic [`BLUR_SUM_W-1:0] sum_q;
    logic [`BLUR_PIX_W-1:0] centre_q;
    logic                   valid_q;

    always_comb begin
        corner_sum = `BLUR_SUM_W'(window.taps[0]) + `BLUR_SUM_W'(window.taps[2])
                   + `BLUR_SUM_W'(window.taps[6]) + `BLUR_SUM_W'(window.taps[8]);
        edge_sum   = `BLUR_SUM_W'(window.taps[1]) + `BLUR_SUM_W'(window.taps[3])
                   + `BLUR_SUM_W'(window.taps[5]) + `BLUR_SUM_W'(window.taps[7]);
        // corners x1, edges x2, centre x4
        weighted   = corner_sum + (edge_sum << 1) + (`BLUR_SUM_W'(window.taps[4]) << 2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= window.valid;
        end
    end

    always_ff @(posedge clk) begin
        sum_q    <= weighted;
        centre_q <= window.taps[4];
    end

    assign stage.sum    = sum_q;
    assign stage.centre = centre_q;
    assign stage.valid  = valid_q;

endmodule

// File: logic/blur_macros.svh
// blur pipeline constants for image geometry, datapath widths and register map
`ifndef BLUR_MACROS_SVH
`define BLUR_MACROS_SVH

// pixels per line, also the depth of each line buffer
`define BLUR_IMG_WIDTH 16

// grayscale pixel width
`define BLUR_PIX_W 8

// weighted sum width, max is 16 * 255 = 4080
`define BLUR_SUM_W 12

// AXI4-Lite byte offsets
`define BLUR_REG_CTRL 4'h0
`define BLUR_REG_STATUS 4'h4

`endif

// File: logic/blur_pkg.sv
// blur pipeline types shared by the register block, the pixel stages and the testbench
`include "blur_macros.svh"

package blur_pkg;

    // one beat of the incoming video stream
    typedef struct packed {
        logic [`BLUR_PIX_W-1:0] pixel;
        logic                   vsync;
        logic                   active;
    } pixel_beat_t;

    // taps[0] is top-left, taps[4] the centre, taps[8] bottom-right
    typedef struct packed {
        logic [0:8][`BLUR_PIX_W-1:0] taps;
        logic                        valid;
    } window_t;

    typedef struct packed {
        logic [`BLUR_SUM_W-1:0] sum;
        logic [`BLUR_PIX_W-1:0] centre;
        logic                   valid;
    } sum_stage_t;

    typedef struct packed {
        logic bypass;
        logic enable;
    } blur_ctrl_t;

    // master side of the AXI4-Lite port
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // slave side of the AXI4-Lite port
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

// File: logic/blur_result.sv
// blur result stage, divide by 16 or pass the centre tap, and register the output
`timescale 1ns/1ns
`include "blur_macros.svh"

module blur_result import blur_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  sum_stage_t             stage,
    input  blur_ctrl_t             ctrl,
    output logic [`BLUR_PIX_W-1:0] pix_out,
    output logic                   pix_out_valid
);

    logic [`BLUR_PIX_W-1:0] norm_pix;

    // truncating divide by 16
    assign norm_pix = stage.sum[`BLUR_SUM_W-1:4];

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_out       <= '0;
            pix_out_valid <= 1'b0;
        end else begin
            pix_out_valid <= stage.valid;
            if (!stage.valid) begin
                // output stays at zero between valid beats
                pix_out <= '0;
            end else if (ctrl.bypass) begin
                pix_out <= stage.centre;
            end else begin
                pix_out <= norm_pix;
            end
        end
    end

endmodule

// File: logic/gaussian_blur_top.sv
// gaussian blur top, register block plus decode, execute and result pixel stages
`timescale 1ns/1ns
`include "blur_macros.svh"

module gaussian_blur_top import blur_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  axil_req_t              axil_req,
    output axil_rsp_t              axil_rsp,
    input  pixel_beat_t            pix_in,
    output logic [`BLUR_PIX_W-1:0] pix_out,
    output logic                   pix_out_valid
);

    blur_ctrl_t ctrl;
    logic       frame_start;
    window_t    window;
    sum_stage_t stage;

    blur_csr u_csr (
        .clk         (clk),
        .reset       (reset),
        .axil_req    (axil_req),
        .frame_start (frame_start),
        .axil_rsp    (axil_rsp),
        .ctrl        (ctrl)
    );

    // window valid on the accept edge, then one cycle each for sum and output
    window_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .pix_in      (pix_in),
        .ctrl        (ctrl),
        .window      (window),
        .frame_start (frame_start)
    );

    blur_execute u_execute (
        .clk    (clk),
        .reset  (reset),
        .window (window),
        .stage  (stage)
    );

    blur_result u_result (
        .clk           (clk),
        .reset         (reset),
        .stage         (stage),
        .ctrl          (ctrl),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid)
    );

endmodule

// File: logic/window_decode.sv
// window decode stage, line buffers and tap rows forming the 3x3 window per frame
`timescale 1ns/1ns
`include "blur_macros.svh"

module window_decode import blur_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  pixel_beat_t pix_in,
    input  blur_ctrl_t  ctrl,
    output window_t     window,
    output logic        frame_start
);

    localparam int W     = `BLUR_IMG_WIDTH;
    localparam int PTR_W = (W > 1) ? $clog2(W) : 1;
    // pixels needed before the first full window
    localparam int PRIME = 2 * W + 3;
    localparam int CNT_W = $clog2(PRIME + 1);

    logic                             vsync_q;
    logic                             accept;
    logic                             win_valid;
    logic [PTR_W-1:0]                 wr_ptr;
    logic [PTR_W-1:0]                 ptr_eff;
    logic [CNT_W-1:0]                 prime_cnt;
    logic [CNT_W-1:0]                 cnt_eff;
    logic [`BLUR_PIX_W-1:0]           line0 [W];
    logic [`BLUR_PIX_W-1:0]           line1 [W];
    logic [0:2][`BLUR_PIX_W-1:0]      top_row;
    logic [0:2][`BLUR_PIX_W-1:0]      mid_row;
    logic [0:2][`BLUR_PIX_W-1:0]      bot_row;
    logic [0:2][`BLUR_PIX_W-1:0]      top_base;
    logic [0:2][`BLUR_PIX_W-1:0]      mid_base;
    logic [0:2][`BLUR_PIX_W-1:0]      bot_base;

    assign frame_start = pix_in.vsync && !vsync_q;
    assign accept      = pix_in.active && ctrl.enable;

    // a vsync edge restarts the frame, a pixel on that same edge becomes pixel 0
    always_comb begin
        if (frame_start) begin
            ptr_eff  = '0;
            cnt_eff  = '0;
            top_base = '0;
            mid_base = '0;
            bot_base = '0;
        end else begin
            ptr_eff  = wr_ptr;
            cnt_eff  = prime_cnt;
            top_base = top_row;
            mid_base = mid_row;
            bot_base = bot_row;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vsync_q   <= 1'b0;
            win_valid <= 1'b0;
            wr_ptr    <= '0;
            prime_cnt <= '0;
            top_row   <= '0;
            mid_row   <= '0;
            bot_row   <= '0;
        end else begin
            vsync_q   <= pix_in.vsync;
            win_valid <= accept && (cnt_eff >= CNT_W'(PRIME - 1));
            if (accept) begin
                // newest pixel enters bottom right, each row shifts left
                bot_row   <= {bot_base[1], bot_base[2], pix_in.pixel};
                mid_row   <= {mid_base[1], mid_base[2], line0[ptr_eff]};
                top_row   <= {top_base[1], top_base[2], line1[ptr_eff]};
                wr_ptr    <= (ptr_eff == PTR_W'(W - 1)) ? '0 : ptr_eff + 1'b1;
                prime_cnt <= (cnt_eff == CNT_W'(PRIME)) ? cnt_eff : cnt_eff + 1'b1;
            end else if (frame_start) begin
                wr_ptr    <= '0;
                prime_cnt <= '0;
                top_row   <= '0;
                mid_row   <= '0;
                bot_row   <= '0;
            end
        end
    end

    // line0 delays the stream by one line, line1 by two
    always_ff @(posedge clk) begin
        if (accept) begin
            line0[ptr_eff] <= pix_in.pixel;
            line1[ptr_eff] <= line0[ptr_eff];
        end
    end

    assign window.taps  = {top_row, mid_row, bot_row};
    assign window.valid = win_valid;

endmodule

// File: verification/gaussian_blur_assertions.sv
// gaussian blur bound checks on AXI4-Lite valid holding and the video output
`timescale 1ns/1ns
`include "blur_macros.svh"

module gaussian_blur_assertions import blur_pkg::*; (
    input logic                   clk,
    input logic                   reset,
    input axil_req_t              axil_req,
    input axil_rsp_t              axil_rsp,
    input logic [`BLUR_PIX_W-1:0] pix_out,
    input logic                   pix_out_valid
);

    // master valids hold until the slave takes them
    aw_hold: assert property (@(posedge clk) disable iff (reset)
        axil_req.awvalid && !axil_rsp.awready |=> axil_req.awvalid)
        else $error("awvalid dropped before its handshake");

    w_hold: assert property (@(posedge clk) disable iff (reset)
        axil_req.wvalid && !axil_rsp.wready |=> axil_req.wvalid)
        else $error("wvalid dropped before its handshake");

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        axil_req.arvalid && !axil_rsp.arready |=> axil_req.arvalid)
        else $error("arvalid dropped before its handshake");

    // slave responses hold until the master takes them
    b_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else $error("bvalid dropped before bready");

    r_hold: assert property (@(posedge clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else $error("rvalid dropped before rready");

    out_zero: assert property (@(posedge clk) disable iff (reset)
        !pix_out_valid |-> pix_out == '0)
        else $error("pix_out nonzero while pix_out_valid is low");

    out_reset: assert property (@(posedge clk) reset |=> !pix_out_valid)
        else $error("pix_out_valid high during reset");

endmodule

bind gaussian_blur_top gaussian_blur_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .pix_out       (pix_out),
    .pix_out_valid (pix_out_valid)
);

// File: verification/gaussian_blur_tb.sv
// gaussian blur testbench running register and frame steps from a table against a kernel model
`timescale 1ns/1ns
`include "blur_macros.svh"

module gaussian_blur_tb import blur_pkg::*; ();

    localparam int W           = `BLUR_IMG_WIDTH;
    // linear index of the first pixel that completes a window
    localparam int FIRST_OUT   = 2 * W + 2;
    localparam int AXI_TIMEOUT = 20;
    localparam int OUT_TIMEOUT = 50;
    localparam logic [31:0] RNG_SEED = 32'ha04f_1c43;
    localparam logic [1:0] OKAY     = 2'b00;
    localparam logic [1:0] SLVERR   = 2'b10;
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_FRAME = 2'd2;
    localparam int NUM_STEPS = 22;

    typedef struct packed {
        logic [1:0]  op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] rdata;
        logic [3:0]  lines;
        logic        gaps;
        logic [31:0] frames;
    } step_t;

    // op, addr, data, resp, rdata, lines, gaps, frames counted after the frame
    step_t steps [NUM_STEPS] = '{
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h3,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  `BLUR_REG_CTRL,   32'h0,  OKAY,   32'h3, 4'd0, 1'b0, 32'd0},
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h1,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  `BLUR_REG_CTRL,   32'h0,  OKAY,   32'h1, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  `BLUR_REG_STATUS, 32'h0,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd4, 1'b0, 32'd1},
        '{OP_WRITE, `BLUR_REG_STATUS, 32'hff, OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  `BLUR_REG_STATUS, 32'h0,  OKAY,   32'h1, 4'd0, 1'b0, 32'd0},
        '{OP_WRITE, 4'h8,             32'h0,  SLVERR, 32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  4'h8,             32'h0,  SLVERR, 32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_READ,  4'hc,             32'h0,  SLVERR, 32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd5, 1'b1, 32'd2},
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h3,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd3, 1'b0, 32'd3},
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h1,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd2, 1'b0, 32'd4},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd3, 1'b1, 32'd5},
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h0,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd3, 1'b1, 32'd6},
        '{OP_WRITE, `BLUR_REG_CTRL,   32'h1,  OKAY,   32'h0, 4'd0, 1'b0, 32'd0},
        '{OP_FRAME, 4'h0,             32'h0,  OKAY,   32'h0, 4'd4, 1'b1, 32'd7},
        '{OP_READ,  `BLUR_REG_STATUS, 32'h0,  OKAY,   32'h7, 4'd0, 1'b0, 32'd0}
    };

    logic                   clk = 1'b0;
    logic                   reset;
    axil_req_t              axil_req;
    axil_rsp_t              axil_rsp;
    pixel_beat_t            pix_in;
    logic [`BLUR_PIX_W-1:0] pix_out;
    logic                   pix_out_valid;

    longint                 cycle = 0;
    int                     checks = 0;
    int                     errors = 0;
    logic                   shadow_enable;
    logic                   shadow_bypass;
    logic [7:0]             frame_pix [$];
    longint                 accept_cycle [$];
    logic [7:0]             out_vals [$];
    longint                 out_cycles [$];

    gaussian_blur_top DUT (
        .clk           (clk),
        .reset         (reset),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .pix_in        (pix_in),
        .pix_out       (pix_out),
        .pix_out_valid (pix_out_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset && pix_out_valid) begin
            out_vals.push_back(pix_out);
            out_cycles.push_back(cycle);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        $display("checks: %0d, mismatches: %0d", checks, errors);
        $display("test failed");
        $finish;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int waited;
        @(posedge clk);
        #1;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            if (waited >= AXI_TIMEOUT) stop_on_timeout("write handshake");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            if (waited >= AXI_TIMEOUT) stop_on_timeout("bvalid");
            @(negedge clk);
            waited++;
        end
        resp = axil_rsp.bresp;
        // bready comes a cycle late and bvalid has to hold meanwhile
        @(posedge clk);
        #1;
        axil_req.bready = 1'b1;
        @(posedge clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int waited;
        @(posedge clk);
        #1;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            if (waited >= AXI_TIMEOUT) stop_on_timeout("read address handshake");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            if (waited >= AXI_TIMEOUT) stop_on_timeout("rvalid");
            @(negedge clk);
            waited++;
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        // rready comes a cycle late and rvalid has to hold meanwhile
        @(posedge clk);
        #1;
        axil_req.rready = 1'b1;
        @(posedge clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic drive_idle(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
            pix_in = '0;
        end
    endtask

    // vsync rises with pixel 0 and random idle beats may follow any pixel but the last
    task automatic send_frame(input int npix, input logic gaps);
        int n;
        frame_pix.delete();
        accept_cycle.delete();
        out_vals.delete();
        out_cycles.delete();
        for (n = 0; n < npix; n++) begin
            frame_pix.push_back(8'($urandom()));
        end
        for (n = 0; n < npix; n++) begin
            @(posedge clk);
            #1;
            pix_in.pixel  = frame_pix[n];
            pix_in.vsync  = (n == 0);
            pix_in.active = 1'b1;
            accept_cycle.push_back(cycle + 1);
            if (gaps && n < npix - 1 && $urandom_range(0, 3) == 0) begin
                drive_idle($urandom_range(1, 3));
            end
        end
        drive_idle(1);
    endtask

    function automatic int expected_count(input int npix);
        if (!shadow_enable || npix <= FIRST_OUT) return 0;
        return npix - FIRST_OUT;
    endfunction

    function automatic int pix_at(input int idx);
        return int'(frame_pix[idx]);
    endfunction

    // 1-2-1 kernel over linear indices with the centre at n-W-1
    function automatic int model_pixel(input int n, input logic bypass);
        int sum;
        sum = pix_at(n - 2*W - 2) + 2 * pix_at(n - 2*W - 1) + pix_at(n - 2*W)
            + 2 * pix_at(n - W - 2) + 4 * pix_at(n - W - 1) + 2 * pix_at(n - W)
            + pix_at(n - 2) + 2 * pix_at(n - 1) + pix_at(n);
        if (bypass) return pix_at(n - W - 1);
        return sum / 16;
    endfunction

    task automatic collect_outputs(input int expected);
        int waited;
        waited = 0;
        while (out_vals.size() < expected) begin
            if (waited >= OUT_TIMEOUT) stop_on_timeout("frame outputs");
            @(posedge clk);
            waited++;
        end
        // the last output trails its window by two stages so a short drain catches extras
        repeat (4) @(posedge clk);
    endtask

    task automatic compare_frame(input int npix);
        int expected;
        int k;
        int n;
        expected = expected_count(npix);
        check_value(32'(out_vals.size()), 32'(expected), "output count");
        for (k = 0; k < out_vals.size() && k < expected; k++) begin
            n = FIRST_OUT + k;
            check_value(32'(out_vals[k]), 32'(model_pixel(n, shadow_bypass)),
                        $sformatf("output for pixel %0d", n));
            check_value(32'(out_cycles[k] - accept_cycle[n]), 32'd2,
                        $sformatf("latency for pixel %0d", n));
        end
    endtask

    task automatic run_step(input step_t s);
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          npix;
        case (s.op)
            OP_WRITE: begin
                axil_write(s.addr, s.data, resp);
                check_value(32'(resp), 32'(s.resp), "write response");
                if (s.addr == `BLUR_REG_CTRL) begin
                    shadow_enable = s.data[0];
                    shadow_bypass = s.data[1];
                end
            end
            OP_READ: begin
                axil_read(s.addr, rdata, resp);
                check_value(32'(resp), 32'(s.resp), "read response");
                check_value(rdata, s.rdata, "read data");
            end
            default: begin
                npix = int'(s.lines) * W;
                send_frame(npix, s.gaps);
                collect_outputs(expected_count(npix));
                compare_frame(npix);
                axil_read(`BLUR_REG_STATUS, rdata, resp);
                check_value(rdata, s.frames, "frame count");
            end
        endcase
    endtask

    initial begin
        int i;
        void'($urandom(RNG_SEED));
        reset         = 1'b1;
        axil_req      = '0;
        pix_in        = '0;
        shadow_enable = 1'b0;
        shadow_bypass = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < NUM_STEPS; i++) begin
            run_step(steps[i]);
        end
        $display("checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
